// File: rtl/mix_pkg.sv
// audio mixer shared definitions
package mix_pkg;

	// sample widths as they leave the sound chips
	// ym3438 style linear output, unsigned
	localparam int FM_LIN_W = 9;
	// ym2612 dac emulation output, two's complement
	localparam int FM_DAC_W = 10;
	// psg sample, already unsigned
	localparam int PSG_W = 16;

	// mix output widths
	localparam int MIX_LIN_W = 16;
	localparam int MIX_DAC_W = 18;

	// linear fm is offset binary, centre sits at half scale
	localparam logic [FM_LIN_W-1:0] FM_LIN_MID = 9'd256;

	// centred linear sample lands in the upper bits of the 16-bit mix
	localparam int LIN_SHIFT = 6;

	// dac gain of 192 built from two shifted copies (128 + 64)
	localparam int DAC_SHIFT_HI = 7;
	localparam int DAC_SHIFT_LO = 6;

	// frame as delivered by the sound chips
	typedef struct packed {
		logic [FM_LIN_W-1:0] lin_l;
		logic [FM_LIN_W-1:0] lin_r;
		logic [FM_DAC_W-1:0] dac_l;
		logic [FM_DAC_W-1:0] dac_r;
		logic [PSG_W-1:0] psg;
	} raw_frame_t;

	// fm channels scaled to mix width
	// psg rides along untouched for the sum stage
	typedef struct packed {
		logic [MIX_LIN_W-1:0] lin_l;
		logic [MIX_LIN_W-1:0] lin_r;
		logic [MIX_DAC_W-1:0] dac_l;
		logic [MIX_DAC_W-1:0] dac_r;
		logic [PSG_W-1:0] psg;
	} scaled_frame_t;

	// final stereo results, both formats
	typedef struct packed {
		logic [MIX_LIN_W-1:0] lin_l;
		logic [MIX_LIN_W-1:0] lin_r;
		logic [MIX_DAC_W-1:0] dac_l;
		logic [MIX_DAC_W-1:0] dac_r;
	} mix_frame_t;

endpackage

// File: rtl/pipe_stage.sv
// valid/ready pipeline register
`timescale 1ns/1ps

module pipe_stage
	import mix_pkg::*;
	#(
	parameter type PAYLOAD_T = raw_frame_t
	)
	(
	input logic MCLK2,
	input logic rst_n_i,

	// upstream side
	input logic up_valid_i,
	output logic up_ready_o,
	input PAYLOAD_T up_data_i,

	// downstream side
	output logic dn_valid_o,
	input logic dn_ready_i,
	output PAYLOAD_T dn_data_o
	);

	logic valid_q;
	PAYLOAD_T data_q;
	logic load;

	// free slot, or the held frame leaves on this edge
	assign up_ready_o = ~valid_q | dn_ready_i;

	assign load = up_valid_i & up_ready_o;

	// occupancy flag
	// when ready is high the slot is either empty or being emptied,
	// so it simply follows the upstream valid
	always_ff @(posedge MCLK2 or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_q <= 1'b0;
		end
		else if (up_ready_o)
		begin
			valid_q <= up_valid_i;
		end
	end

	// payload only moves on an accepted transfer
	always_ff @(posedge MCLK2)
	begin
		if (load)
		begin
			data_q <= up_data_i;
		end
	end

	assign dn_valid_o = valid_q;
	assign dn_data_o = data_q;

endmodule

// File: rtl/fm_scale.sv
// fm sample scaling stage
`timescale 1ns/1ps

module fm_scale
	import mix_pkg::*;
	(
	input logic MCLK2,
	input logic rst_n_i,

	// raw frames in
	input logic up_valid_i,
	output logic up_ready_o,
	input raw_frame_t up_data_i,

	// scaled frames out
	output logic dn_valid_o,
	input logic dn_ready_i,
	output scaled_frame_t dn_data_o
	);

	scaled_frame_t scaled;

	// linear path
	// remove the half scale offset, then move into the top of the word
	function automatic logic [MIX_LIN_W-1:0] scale_lin(input logic [FM_LIN_W-1:0] sample);
		logic signed [FM_LIN_W-1:0] centred;
		logic signed [MIX_LIN_W-1:0] wide;
		centred = signed'(sample - FM_LIN_MID);
		// size cast of a signed value sign-extends
		wide = MIX_LIN_W'(centred);
		return wide <<< LIN_SHIFT;
	endfunction

	// dac path
	// x * 192 as (x << 7) + (x << 6), wraps in 18 bits
	function automatic logic [MIX_DAC_W-1:0] scale_dac(input logic [FM_DAC_W-1:0] sample);
		logic signed [FM_DAC_W-1:0] code;
		logic signed [MIX_DAC_W-1:0] wide;
		code = signed'(sample);
		wide = MIX_DAC_W'(code);
		return (wide <<< DAC_SHIFT_HI) + (wide <<< DAC_SHIFT_LO);
	endfunction

	always_comb
	begin
		scaled.lin_l = scale_lin(up_data_i.lin_l);
		scaled.lin_r = scale_lin(up_data_i.lin_r);
		scaled.dac_l = scale_dac(up_data_i.dac_l);
		scaled.dac_r = scale_dac(up_data_i.dac_r);
		// psg is needed one stage later
		scaled.psg = up_data_i.psg;
	end

	// scaled result is captured together with the frame handshake
	pipe_stage
		#(
		.PAYLOAD_T(scaled_frame_t)
		)
	scale_reg_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.up_valid_i(up_valid_i),
		.up_ready_o(up_ready_o),
		.up_data_i(scaled),
		.dn_valid_o(dn_valid_o),
		.dn_ready_i(dn_ready_i),
		.dn_data_o(dn_data_o)
		);

endmodule

// File: rtl/mix_sum.sv
// psg summing stage
`timescale 1ns/1ps

module mix_sum
	import mix_pkg::*;
	(
	input logic MCLK2,
	input logic rst_n_i,

	// scaled frames in
	input logic up_valid_i,
	output logic up_ready_o,
	input scaled_frame_t up_data_i,

	// mixed frames out
	output logic dn_valid_o,
	input logic dn_ready_i,
	output mix_frame_t dn_data_o
	);

	mix_frame_t mixed;
	logic [MIX_DAC_W-1:0] psg_wide;

	// psg is unsigned, pad with zeros for the dac mix
	assign psg_wide = MIX_DAC_W'(up_data_i.psg);

	always_comb
	begin
		// both sums wrap at their own width, no saturation
		mixed.lin_l = up_data_i.lin_l + up_data_i.psg;
		mixed.lin_r = up_data_i.lin_r + up_data_i.psg;
		mixed.dac_l = up_data_i.dac_l + psg_wide;
		mixed.dac_r = up_data_i.dac_r + psg_wide;
	end

	// output register
	pipe_stage
		#(
		.PAYLOAD_T(mix_frame_t)
		)
	sum_reg_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.up_valid_i(up_valid_i),
		.up_ready_o(up_ready_o),
		.up_data_i(mixed),
		.dn_valid_o(dn_valid_o),
		.dn_ready_i(dn_ready_i),
		.dn_data_o(dn_data_o)
		);

endmodule

// File: rtl/audio_mixer_top.sv
// audio output mixer
`timescale 1ns/1ps

module audio_mixer_top
	import mix_pkg::*;
	(
	input logic MCLK2,
	input logic rst_n_i,

	// input frame handshake
	input logic in_valid_i,
	output logic in_ready_o,

	// fm linear, unsigned
	input logic [FM_LIN_W-1:0] mol_i,
	input logic [FM_LIN_W-1:0] mor_i,
	// fm dac emulation, signed
	input logic [FM_DAC_W-1:0] mol_dac_i,
	input logic [FM_DAC_W-1:0] mor_dac_i,
	input logic [PSG_W-1:0] psg_i,

	// output frame handshake
	output logic out_valid_o,
	input logic out_ready_i,

	// stereo mixes
	output logic [MIX_LIN_W-1:0] lin_l_o,
	output logic [MIX_LIN_W-1:0] lin_r_o,
	output logic [MIX_DAC_W-1:0] dac_l_o,
	output logic [MIX_DAC_W-1:0] dac_r_o
	);

	raw_frame_t in_frame;

	// input register to scale stage
	logic raw_valid;
	logic raw_ready;
	raw_frame_t raw_frame;

	// scale stage to sum stage
	logic scl_valid;
	logic scl_ready;
	scaled_frame_t scl_frame;

	mix_frame_t out_frame;

	assign in_frame.lin_l = mol_i;
	assign in_frame.lin_r = mor_i;
	assign in_frame.dac_l = mol_dac_i;
	assign in_frame.dac_r = mor_dac_i;
	assign in_frame.psg = psg_i;

	// stage 1, register the chip samples as they are
	pipe_stage
		#(
		.PAYLOAD_T(raw_frame_t)
		)
	in_reg_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.up_valid_i(in_valid_i),
		.up_ready_o(in_ready_o),
		.up_data_i(in_frame),
		.dn_valid_o(raw_valid),
		.dn_ready_i(raw_ready),
		.dn_data_o(raw_frame)
		);

	// stage 2
	fm_scale fm_scale_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.up_valid_i(raw_valid),
		.up_ready_o(raw_ready),
		.up_data_i(raw_frame),
		.dn_valid_o(scl_valid),
		.dn_ready_i(scl_ready),
		.dn_data_o(scl_frame)
		);

	// stage 3
	mix_sum mix_sum_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.up_valid_i(scl_valid),
		.up_ready_o(scl_ready),
		.up_data_i(scl_frame),
		.dn_valid_o(out_valid_o),
		.dn_ready_i(out_ready_i),
		.dn_data_o(out_frame)
		);

	assign lin_l_o = out_frame.lin_l;
	assign lin_r_o = out_frame.lin_r;
	assign dac_l_o = out_frame.dac_l;
	assign dac_r_o = out_frame.dac_r;

endmodule

// File: dv/audio_mixer_chk.sv
// output handshake assertions
`timescale 1ns/1ps

module audio_mixer_chk
	import mix_pkg::*;
	(
	input logic MCLK2,
	input logic rst_n_i,
	input logic out_valid_i,
	input logic out_ready_i,
	input logic [MIX_LIN_W-1:0] lin_l_i,
	input logic [MIX_LIN_W-1:0] lin_r_i,
	input logic [MIX_DAC_W-1:0] dac_l_i,
	input logic [MIX_DAC_W-1:0] dac_r_i
	);

	// a stalled output frame waits unchanged for the sink
	property stall_hold;
		@(posedge MCLK2) disable iff (!rst_n_i)
		(out_valid_i && !out_ready_i) |=>
			(out_valid_i && $stable(lin_l_i) && $stable(lin_r_i)
			&& $stable(dac_l_i) && $stable(dac_r_i));
	endproperty

	stall_hold_a: assert property (stall_hold)
		else $error("output frame dropped or changed while out_ready_i was low");

	// every stage is cleared by the asynchronous reset
	reset_idle_a: assert property (@(posedge MCLK2) !rst_n_i |-> !out_valid_i)
		else $error("out_valid_o high during reset");

endmodule

bind audio_mixer_top audio_mixer_chk audio_mixer_chk_inst
	(
	.MCLK2(MCLK2),
	.rst_n_i(rst_n_i),
	.out_valid_i(out_valid_o),
	.out_ready_i(out_ready_i),
	.lin_l_i(lin_l_o),
	.lin_r_i(lin_r_o),
	.dac_l_i(dac_l_o),
	.dac_r_i(dac_r_o)
	);

// File: dv/tb_audio_mixer.sv
// audio mixer testbench
`timescale 1ns/1ps

module tb_audio_mixer
	import mix_pkg::*;
	();

	localparam int LIN_FRAMES = 48;
	localparam int DAC_FRAMES = 48;
	localparam int LAT_FRAMES = 24;
	localparam int BP_FRAMES = 200;
	// a stalled frame waits about four cycles for a ready output
	localparam int RUN_CYCLES = 8 + LIN_FRAMES + DAC_FRAMES + LAT_FRAMES + 4 * BP_FRAMES + 80;
	localparam int MARGIN = 4;

	logic MCLK2;
	logic rst_n_i;
	logic in_valid_i;
	logic in_ready_o;
	logic [FM_LIN_W-1:0] mol_i;
	logic [FM_LIN_W-1:0] mor_i;
	logic [FM_DAC_W-1:0] mol_dac_i;
	logic [FM_DAC_W-1:0] mor_dac_i;
	logic [PSG_W-1:0] psg_i;
	logic out_valid_o;
	logic out_ready_i;
	logic [MIX_LIN_W-1:0] lin_l_o;
	logic [MIX_LIN_W-1:0] lin_r_o;
	logic [MIX_DAC_W-1:0] dac_l_o;
	logic [MIX_DAC_W-1:0] dac_r_o;

	logic [31:0] lfsr_state;
	raw_frame_t stim_q[$];
	// expected results, one per frame in flight
	mix_frame_t exp_q[$];
	string cur_test;
	bit in_fire;
	int cyc;
	int first_in_cyc;
	int first_out_cyc;
	int prev_out_cyc;
	int gap_cnt;
	int full_stalls;
	int checks;
	int errors;
	int tests;
	int tests_failed;
	int test_err_base;

	audio_mixer_top audio_mixer_top_inst
		(
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.mol_i(mol_i),
		.mor_i(mor_i),
		.mol_dac_i(mol_dac_i),
		.mor_dac_i(mor_dac_i),
		.psg_i(psg_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.lin_l_o(lin_l_o),
		.lin_r_o(lin_r_o),
		.dac_l_o(dac_l_o),
		.dac_r_o(dac_r_o)
		);

	always #20 MCLK2 = ~MCLK2;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// offset binary minus half scale, times 64, plus psg, 16-bit wrap
	function automatic logic [15:0] lin_ref(input logic [8:0] fm, input logic [15:0] psg);
		int centred;
		centred = int'(fm) - 256;
		return 16'(centred * 64 + int'(psg));
	endfunction

	// two's complement code times 192, plus psg, 18-bit wrap
	function automatic logic [17:0] dac_ref(input logic [9:0] fm, input logic [15:0] psg);
		int code;
		code = int'($signed(fm));
		return 18'(code * 192 + int'(psg));
	endfunction

	function automatic mix_frame_t model_mix(input raw_frame_t f);
		mix_frame_t m;
		m.lin_l = lin_ref(f.lin_l, f.psg);
		m.lin_r = lin_ref(f.lin_r, f.psg);
		m.dac_l = dac_ref(f.dac_l, f.psg);
		m.dac_r = dac_ref(f.dac_r, f.psg);
		return m;
	endfunction

	function automatic raw_frame_t make_frame(input logic [8:0] ll, input logic [8:0] lr,
		input logic [9:0] dl, input logic [9:0] dr, input logic [15:0] p);
		raw_frame_t f;
		f.lin_l = ll;
		f.lin_r = lr;
		f.dac_l = dl;
		f.dac_r = dr;
		f.psg = p;
		return f;
	endfunction

	task automatic rand_frame(output raw_frame_t f);
		logic [31:0] v;
		take_bits(FM_LIN_W, v);
		f.lin_l = v[FM_LIN_W-1:0];
		take_bits(FM_LIN_W, v);
		f.lin_r = v[FM_LIN_W-1:0];
		take_bits(FM_DAC_W, v);
		f.dac_l = v[FM_DAC_W-1:0];
		take_bits(FM_DAC_W, v);
		f.dac_r = v[FM_DAC_W-1:0];
		take_bits(PSG_W, v);
		f.psg = v[PSG_W-1:0];
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err_base = errors;
		tests++;
		first_in_cyc = -1;
		first_out_cyc = -1;
		prev_out_cyc = -1;
		gap_cnt = 0;
	endtask

	task automatic end_test();
		int n;
		n = errors - test_err_base;
		if (n == 0)
		begin
			$display("test %s passed", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, n);
		end
	endtask

	// push every queued frame through, then let the pipeline drain
	task automatic send_frames(input bit rand_in, input bit rand_out);
		logic [31:0] b;
		raw_frame_t f;
		bit done;
		int n;
		done = 1'b0;
		while (!done)
		begin
			@(posedge MCLK2);
			if (rand_out)
			begin
				take_bits(2, b);
				out_ready_i <= &b[1:0];
			end
			else
			begin
				out_ready_i <= 1'b1;
			end
			// payload only changes once the held frame was taken
			if (!in_valid_i || in_fire)
			begin
				take_bits(2, b);
				if (stim_q.size() == 0)
				begin
					in_valid_i <= 1'b0;
					out_ready_i <= 1'b1;
					done = 1'b1;
				end
				else if (rand_in && b[1:0] == 2'b00)
				begin
					in_valid_i <= 1'b0;
				end
				else
				begin
					f = stim_q.pop_front();
					mol_i <= f.lin_l;
					mor_i <= f.lin_r;
					mol_dac_i <= f.dac_l;
					mor_dac_i <= f.dac_r;
					psg_i <= f.psg;
					in_valid_i <= 1'b1;
				end
			end
		end
		n = 0;
		while (exp_q.size() != 0 && n < 16)
		begin
			@(posedge MCLK2);
			n++;
		end
		check({cur_test, " frames left"}, 0, 32'(exp_q.size()));
	endtask

	// scoreboard, sampled mid-cycle while everything is settled
	always @(negedge MCLK2)
	begin
		mix_frame_t want;
		if (rst_n_i)
		begin
			cyc++;
			if (exp_q.size() == 3 && !out_ready_i)
			begin
				full_stalls++;
				check({cur_test, " in_ready_o with three frames held"}, 0, 32'(in_ready_o));
			end
			if (out_valid_o && out_ready_i)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("ERROR %s output frame appeared with none expected", cur_test);
				end
				else
				begin
					want = exp_q.pop_front();
					check({cur_test, " lin_l_o"}, 32'(want.lin_l), 32'(lin_l_o));
					check({cur_test, " lin_r_o"}, 32'(want.lin_r), 32'(lin_r_o));
					check({cur_test, " dac_l_o"}, 32'(want.dac_l), 32'(dac_l_o));
					check({cur_test, " dac_r_o"}, 32'(want.dac_r), 32'(dac_r_o));
				end
				if (first_out_cyc < 0)
					first_out_cyc = cyc;
				else if (cyc != prev_out_cyc + 1)
					gap_cnt++;
				prev_out_cyc = cyc;
			end
			in_fire = in_valid_i && in_ready_o;
			if (in_fire)
			begin
				exp_q.push_back(model_mix(make_frame(mol_i, mor_i, mol_dac_i, mor_dac_i, psg_i)));
				if (first_in_cyc < 0)
					first_in_cyc = cyc;
			end
		end
	end

	initial
	begin
		raw_frame_t f;
		logic [8:0] lin_edge [0:2];
		logic [9:0] dac_edge [0:3];
		int i;
		int j;
		MCLK2 = 1'b0;
		rst_n_i = 1'b1;
		in_valid_i = 1'b0;
		out_ready_i = 1'b0;
		mol_i = '0;
		mor_i = '0;
		mol_dac_i = '0;
		mor_dac_i = '0;
		psg_i = '0;
		lfsr_state = 32'h84ba;
		in_fire = 1'b0;
		cyc = 0;
		full_stalls = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		tests_failed = 0;
		lin_edge[0] = 9'd0;
		lin_edge[1] = 9'd256;
		lin_edge[2] = 9'd511;
		// most negative, most positive, zero, minus one
		dac_edge[0] = 10'h200;
		dac_edge[1] = 10'h1ff;
		dac_edge[2] = 10'h000;
		dac_edge[3] = 10'h3ff;

		@(posedge MCLK2);
		rst_n_i <= 1'b0;
		repeat (8) @(posedge MCLK2);
		rst_n_i <= 1'b1;
		@(negedge MCLK2);
		begin_test("reset");
		check("reset out_valid_o", 0, 32'(out_valid_o));
		check("reset in_ready_o", 1, 32'(in_ready_o));
		end_test();

		begin_test("linear_mix");
		for (i = 0; i < 3; i++)
			for (j = 0; j < 3; j++)
				stim_q.push_back(make_frame(lin_edge[i], lin_edge[j], 10'h000, 10'h000,
					(j == 1) ? 16'h8000 : 16'hffff));
		repeat (LIN_FRAMES)
		begin
			rand_frame(f);
			stim_q.push_back(f);
		end
		send_frames(1'b0, 1'b0);
		end_test();

		begin_test("dac_mix");
		for (i = 0; i < 4; i++)
			for (j = 0; j < 4; j++)
				stim_q.push_back(make_frame(9'd256, 9'd256, dac_edge[i], dac_edge[j],
					(j[0]) ? 16'h0000 : 16'hffff));
		repeat (DAC_FRAMES)
		begin
			rand_frame(f);
			stim_q.push_back(f);
		end
		send_frames(1'b0, 1'b0);
		end_test();

		begin_test("latency");
		repeat (LAT_FRAMES)
		begin
			rand_frame(f);
			stim_q.push_back(f);
		end
		send_frames(1'b0, 1'b0);
		check("latency first result", 3, 32'(first_out_cyc - first_in_cyc));
		check("latency result gaps", 0, 32'(gap_cnt));
		end_test();

		begin_test("backpressure");
		full_stalls = 0;
		repeat (BP_FRAMES)
		begin
			rand_frame(f);
			stim_q.push_back(f);
		end
		send_frames(1'b1, 1'b1);
		if (full_stalls == 0)
		begin
			errors++;
			$display("ERROR backpressure never filled all three stages with the output stalled");
		end
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (RUN_CYCLES * MARGIN) @(posedge MCLK2);
		$display("ERROR run timed out after %0d cycles in test %s", RUN_CYCLES * MARGIN, cur_test);
		$display("Something failed");
		$finish;
	end

endmodule

// File: filelist.f
rtl/mix_pkg.sv
rtl/pipe_stage.sv
rtl/fm_scale.sv
rtl/mix_sum.sv
rtl/audio_mixer_top.sv
dv/audio_mixer_chk.sv
dv/tb_audio_mixer.sv

// File: run.sh
#!/bin/sh
# build and run the audio mixer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f filelist.f \
	--top-module tb_audio_mixer \
	-o tb_audio_mixer

# a failing assertion stops the run early, so keep going to the search
out=$(./obj_dir/tb_audio_mixer 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'
then
	exit 0
fi
exit 1
